//--- include/neighbor_macros.svh
`ifndef neighbor_macros_svh
`define neighbor_macros_svh

// width of one neighbor ID.
`define neighbor_id_width 7

// two IDs share one SRAM word.
`define neighbor_word_width 14

// 64 words in every bank.
`define neighbor_addr_width 6

// degrees run from 1 to 15.
`define degree_width 4

// neighbor banks and their select field.
`define num_banks 4
`define bank_sel_width 2

// edge PEs that own the returned lists.
`define num_edge_pe 4
`define pe_tag_width 2

`endif

//--- logic/neighbor_pkg.sv
`include "neighbor_macros.svh"

package neighbor_pkg;

    // one vertex lookup as it arrives from outside.
    typedef struct packed {
        logic                             valid;
        logic [`pe_tag_width-1:0]         pe_tag;
        logic [`bank_sel_width-1:0]       bank;
        logic [`neighbor_addr_width-1:0]  start_addr;
        logic [`degree_width-1:0]         degree;
    } neighbor_request_t;

    // lookup after routing, bank field no longer needed.
    typedef struct packed {
        logic                             valid;
        logic [`pe_tag_width-1:0]         pe_tag;
        logic [`neighbor_addr_width-1:0]  start_addr;
        logic [`degree_width-1:0]         degree;
    } bank_request_t;

    typedef struct packed {
        logic                             cen;   // chip enable, active low.
        logic                             wen;   // write enable, active low.
        logic [`neighbor_addr_width-1:0]  a;
    } sram_port_t;

    // initialisation write into one bank.
    typedef struct packed {
        logic                             valid;
        logic [`bank_sel_width-1:0]       bank;
        logic [`neighbor_addr_width-1:0]  addr;
        logic [`neighbor_word_width-1:0]  data;
    } sram_load_t;

    typedef struct packed {
        logic                             valid;
        logic                             sos;   // first word of a list.
        logic                             eos;   // last word of a list.
        logic [`neighbor_word_width-1:0]  data;
        logic [`pe_tag_width-1:0]         pe_tag;
        logic [`degree_width-1:0]         degree;
    } neighbor_flit_t;

    typedef enum logic {
        BANK_IDLE,
        BANK_STREAM
    } bank_state_t;

endpackage

//--- logic/neighbor_mem_cntl.sv
`include "neighbor_macros.svh"

module neighbor_mem_cntl (
    input  logic                                          clk,
    input  logic                                          reset,
    input  neighbor_pkg::neighbor_request_t               req,
    input  neighbor_pkg::neighbor_flit_t [`num_banks-1:0] flits,
    output logic                                          req_stall,
    output neighbor_pkg::bank_request_t [`num_banks-1:0]  bank_req
);

    logic [`num_banks-1:0]            occupied;        // bank holds a list in flight.
    logic [`num_banks-1:0]            occupied_next;
    logic [`num_banks-1:0]            target;          // one-hot decode of req.bank.
    logic [`num_banks-1:0]            list_done;       // eos seen on that bank.
    logic [`num_banks-1:0]            strobe;
    logic                             accept;

    // request payload, shared by all banks; only the strobed one looks at it.
    logic [`pe_tag_width-1:0]         held_tag;
    logic [`neighbor_addr_width-1:0]  held_start;
    logic [`degree_width-1:0]         held_degree;

    always_comb begin
        for (int b = 0; b < `num_banks; b++) begin
            target[b]    = (req.bank == `bank_sel_width'(b));
            list_done[b] = flits[b].valid && flits[b].eos;
        end
    end

    assign req_stall = req.valid && occupied[req.bank];   // only the addressed bank matters.
    assign accept    = req.valid && !req_stall;

    // a bank cannot finish and be granted in the same cycle, stall prevents it.
    assign occupied_next = (occupied & ~list_done) | (target & {`num_banks{accept}});

    always_ff @(posedge clk) begin
        if (reset) begin
            occupied <= '0;
            strobe   <= '0;
        end else begin
            occupied <= occupied_next;
            strobe   <= target & {`num_banks{accept}};   // one cycle per accepted request.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_tag    <= req.pe_tag;
            held_start  <= req.start_addr;
            held_degree <= req.degree;
        end
    end

    always_comb begin
        for (int b = 0; b < `num_banks; b++) begin
            bank_req[b].valid      = strobe[b];
            bank_req[b].pe_tag     = held_tag;
            bank_req[b].start_addr = held_start;
            bank_req[b].degree     = held_degree;
        end
    end

endmodule

//--- logic/neighbor_bank_cntl.sv
`include "neighbor_macros.svh"

module neighbor_bank_cntl (
    input  logic                             clk,
    input  logic                             reset,
    input  neighbor_pkg::bank_request_t      bank_req,
    input  logic [`neighbor_word_width-1:0]  rdata,
    output neighbor_pkg::sram_port_t         sram,
    output neighbor_pkg::neighbor_flit_t     flit,
    output logic                             busy
);
    import neighbor_pkg::*;

    // counts IDs in steps of two, so one bit wider than the degree.
    localparam int cnt_width = `degree_width + 1;

    bank_state_t                      state;
    bank_state_t                      state_next;
    sram_port_t                       sram_next;
    neighbor_flit_t                   flit_next;
    logic [`pe_tag_width-1:0]         tag_q;
    logic [`pe_tag_width-1:0]         tag_next;
    logic [`degree_width-1:0]         degree_q;
    logic [`degree_width-1:0]         degree_next;
    logic [`neighbor_addr_width-1:0]  last_addr;       // address of the final word.
    logic [`neighbor_addr_width-1:0]  last_addr_next;
    logic [`degree_width-1:0]         req_span;        // words after the first.
    logic [cnt_width-1:0]             cnt;
    logic [cnt_width-1:0]             cnt_next;
    logic [cnt_width-1:0]             cnt_step;
    logic                             rd_valid;        // rdata holds a word this cycle.
    logic                             last_word;

    assign req_span  = (bank_req.degree - 1'b1) >> 1;
    assign cnt_step  = cnt + cnt_width'(2);
    assign last_word = (cnt_step >= {1'b0, degree_q});
    assign busy      = (state == BANK_STREAM);

    always_comb begin
        state_next     = state;
        sram_next      = sram;
        tag_next       = tag_q;
        degree_next    = degree_q;
        last_addr_next = last_addr;
        cnt_next       = cnt;
        flit_next      = '0;
        case (state)
            BANK_IDLE: begin
                sram_next.cen = 1'b1;
                sram_next.wen = 1'b1;
                if (bank_req.valid) begin
                    state_next     = BANK_STREAM;
                    sram_next.cen  = 1'b0;   // first read goes out next cycle.
                    sram_next.a    = bank_req.start_addr;
                    tag_next       = bank_req.pe_tag;
                    degree_next    = bank_req.degree;
                    last_addr_next = bank_req.start_addr + `neighbor_addr_width'(req_span);
                    cnt_next       = '0;
                end
            end
            BANK_STREAM: begin
                // reads run one word ahead of the flits until the last address is out
                if (!sram.cen && (sram.a != last_addr)) begin
                    sram_next.a = sram.a + 1'b1;
                end else begin
                    sram_next.cen = 1'b1;
                end
                if (rd_valid) begin
                    cnt_next         = cnt_step;
                    flit_next.valid  = 1'b1;
                    flit_next.sos    = (cnt == '0);
                    flit_next.eos    = last_word;
                    flit_next.pe_tag = tag_q;
                    flit_next.degree = degree_q;
                    flit_next.data   = rdata;
                    if (last_word && degree_q[0]) begin
                        // odd degree leaves the upper ID of the last word unused.
                        flit_next.data = {{`neighbor_id_width{1'b0}},
                                          rdata[`neighbor_id_width-1:0]};
                    end
                    if (last_word) begin
                        state_next = BANK_IDLE;
                    end
                end
            end
            default: begin
                state_next    = BANK_IDLE;
                sram_next.cen = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= BANK_IDLE;
            sram.cen   <= 1'b1;
            sram.wen   <= 1'b1;
            sram.a     <= '0;
            rd_valid   <= 1'b0;
            cnt        <= '0;
            flit       <= '0;
        end else begin
            state      <= state_next;
            sram       <= sram_next;
            rd_valid   <= ~sram.cen;   // SRAM answers one cycle after the enable.
            cnt        <= cnt_next;
            flit       <= flit_next;
        end
    end

    always_ff @(posedge clk) begin
        tag_q     <= tag_next;
        degree_q  <= degree_next;
        last_addr <= last_addr_next;
    end

endmodule

//--- logic/neighbor_sram.sv
`include "neighbor_macros.svh"

module neighbor_sram #(
    parameter int bank_index = 0
) (
    input  logic                             clk,
    input  neighbor_pkg::sram_port_t         port,
    input  neighbor_pkg::sram_load_t         load,
    output logic [`neighbor_word_width-1:0]  rdata
);

    localparam int depth = 1 << `neighbor_addr_width;
    localparam logic [`bank_sel_width-1:0] own_bank = `bank_sel_width'(bank_index);

    logic [`neighbor_word_width-1:0] mem [depth];

    // registered read, data shows up the cycle after the enable.
    always_ff @(posedge clk) begin
        if (!port.cen && port.wen) begin
            rdata <= mem[port.a];
        end
    end

    always_ff @(posedge clk) begin
        if (load.valid && (load.bank == own_bank)) begin
            mem[load.addr] <= load.data;   // init path only.
        end
    end

endmodule

//--- logic/neighbor_fetch_top.sv
`include "neighbor_macros.svh"

module neighbor_fetch_top (
    input  logic                                          clk,
    input  logic                                          reset,
    input  neighbor_pkg::neighbor_request_t               req,
    input  neighbor_pkg::sram_load_t                      load,
    output logic                                          req_stall,
    output neighbor_pkg::neighbor_flit_t [`num_banks-1:0] flits,
    output logic [`num_banks-1:0]                         bank_busy
);
    import neighbor_pkg::*;

    bank_request_t [`num_banks-1:0]                        bank_req;
    sram_port_t [`num_banks-1:0]                           sram_port;
    logic [`num_banks-1:0][`neighbor_word_width-1:0]       sram_rdata;

    neighbor_mem_cntl u_mem_cntl (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .flits     (flits),       // eos frees the bank.
        .req_stall (req_stall),
        .bank_req  (bank_req)
    );

    for (genvar b = 0; b < `num_banks; b++) begin : g_bank
        neighbor_bank_cntl u_bank_cntl (
            .clk      (clk),
            .reset    (reset),
            .bank_req (bank_req[b]),
            .rdata    (sram_rdata[b]),
            .sram     (sram_port[b]),
            .flit     (flits[b]),
            .busy     (bank_busy[b])
        );

        neighbor_sram #(
            .bank_index (b)
        ) u_sram (
            .clk   (clk),
            .port  (sram_port[b]),
            .load  (load),         // every bank sees the load, only one takes it.
            .rdata (sram_rdata[b])
        );
    end

endmodule

//--- testbench/neighbor_fetch_asserts.sv
`include "neighbor_macros.svh"

module neighbor_fetch_asserts #(
    parameter bit bank_side = 1'b1   // bank controller checks, else request checks.
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cen,
    input  neighbor_pkg::neighbor_flit_t  flit,
    input  logic                          req_valid,
    input  logic                          req_stall
);

    if (bank_side) begin : g_bank_checks
        logic sos_due;   // next valid flit opens a list.

        always_ff @(posedge clk) begin
            if (reset) begin
                sos_due <= 1'b1;
            end else if (flit.valid) begin
                sos_due <= flit.eos;
            end
        end

        a_cen_in_reset: assert property (
            @(posedge clk) reset && $past(reset) |-> cen
        ) else $error("SRAM enabled during reset");

        a_gap_after_eos: assert property (
            @(posedge clk) disable iff (reset) flit.valid && flit.eos |=> !flit.valid
        ) else $error("flit right after eos on the same bank");

        a_first_has_sos: assert property (
            @(posedge clk) disable iff (reset) flit.valid && sos_due |-> flit.sos
        ) else $error("first flit of a list without sos");
    end else begin : g_req_checks
        a_no_idle_stall: assert property (
            @(posedge clk) disable iff (reset) !req_valid |-> !req_stall
        ) else $error("stall raised with no request");
    end

endmodule

//--- testbench/neighbor_fetch_tb.sv
`include "neighbor_macros.svh"

module neighbor_fetch_tb;
    import neighbor_pkg::*;

    localparam int clk_period     = 40;
    localparam int reset_cycles   = 8;
    localparam int words_per_bank = 1 << `neighbor_addr_width;
    localparam string cases_path  = "testbench/neighbor_cases.txt";

    logic                             clk;
    logic                             reset;
    neighbor_request_t                req;
    sram_load_t                       load;
    logic                             req_stall;
    neighbor_flit_t [`num_banks-1:0]  flits;
    logic [`num_banks-1:0]            bank_busy;

    // shadow copy of every SRAM word written so far.
    logic [`neighbor_word_width-1:0]  shadow [`num_banks][words_per_bank];

    string  req_name [$];
    int     req_bank [$];
    int     req_start [$];
    int     req_degree [$];
    int     req_tag [$];
    int     req_stall_exp [$];
    int     load_bank [$];
    int     load_addr [$];
    int     load_count [$];
    int     load_base [$];

    // flits still owed by each bank, with the cycle they are due in.
    neighbor_flit_t  exp_flit [`num_banks][$];
    int              exp_due [`num_banks][$];
    string           exp_name [`num_banks][$];
    int              last_flit_cycle [`num_banks];
    int              accept_at [`num_banks];   // cycle of the latest accepted request.

    int  cycle;
    int  watchdog_cycles;
    bit  checking;
    bit  run_passed;
    bit  fail_reported;

    neighbor_fetch_top UUT (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .load      (load),
        .req_stall (req_stall),
        .flits     (flits),
        .bank_busy (bank_busy)
    );

    bind neighbor_bank_cntl neighbor_fetch_asserts u_bank_asserts (
        .clk       (clk),
        .reset     (reset),
        .cen       (sram.cen),
        .flit      (flit),
        .req_valid (),
        .req_stall ()
    );

    bind neighbor_mem_cntl neighbor_fetch_asserts #(
        .bank_side (1'b0)
    ) u_mem_asserts (
        .clk       (clk),
        .reset     (reset),
        .cen       (),
        .flit      (),
        .req_valid (req.valid),
        .req_stall (req_stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic report_failure();
        fail_reported = 1'b1;
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_flit(string name, neighbor_flit_t expected, neighbor_flit_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_stall(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAIL %s stall expected %b actual %b", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_busy(string name, logic [`num_banks-1:0] expected,
                              logic [`num_banks-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s busy expected %b actual %b", name, expected, actual);
            report_failure();
        end
    endtask

    // init pattern, mixes all address bits into the word.
    function automatic logic [`neighbor_word_width-1:0] fill_word(int base, int addr);
        return `neighbor_word_width'(base ^ (addr * 131) ^ (addr << 8));
    endfunction

    // bank stays occupied up to and including the cycle its eos is visible
    function automatic logic stall_model(int b);
        return cycle <= last_flit_cycle[b];
    endfunction

    task automatic read_cases();
        int     fd;
        int     n;
        int     f1, f2, f3, f4, f5;
        string  line;
        string  kind;
        string  name;
        fd = $fopen(cases_path, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", cases_path);
            report_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            n = $sscanf(line, "%s", kind);
            if (n == 1 && kind == "L") begin
                n = $sscanf(line, "%s %h %h %h %h", kind, f1, f2, f3, f4);
                load_bank.push_back(f1);
                load_addr.push_back(f2);
                load_count.push_back(f3);
                load_base.push_back(f4);
            end else if (n == 1 && kind == "R") begin
                n = $sscanf(line, "%s %s %h %h %h %h %h", kind, name, f1, f2, f3, f4, f5);
                req_name.push_back(name);
                req_bank.push_back(f1);
                req_start.push_back(f2);
                req_degree.push_back(f3);
                req_tag.push_back(f4);
                req_stall_exp.push_back(f5);
            end
        end
        $fclose(fd);
    endtask

    task automatic write_word(int b, int addr, logic [`neighbor_word_width-1:0] data);
        @(negedge clk);
        load.valid = 1'b1;
        load.bank  = `bank_sel_width'(b);
        load.addr  = `neighbor_addr_width'(addr);
        load.data  = data;
        shadow[b][addr % words_per_bank] = data;
    endtask

    task automatic load_memories();
        int addr;
        for (int i = 0; i < load_bank.size(); i++) begin
            for (int k = 0; k < load_count[i]; k++) begin
                addr = (load_addr[i] + k) % words_per_bank;
                write_word(load_bank[i], addr, fill_word(load_base[i], addr));
            end
        end
        // random word right behind each list.
        for (int i = 0; i < req_name.size(); i++) begin
            addr = (req_start[i] + (req_degree[i] + 1) / 2) % words_per_bank;
            write_word(req_bank[i], addr, `neighbor_word_width'($urandom));
        end
        @(negedge clk);
        load = '0;
    endtask

    task automatic issue_request(int i);
        int              b;
        int              words;
        int              accept_cycle;
        neighbor_flit_t  f;
        b = req_bank[i];
        words = (req_degree[i] + 1) / 2;
        @(negedge clk);
        req.valid      = 1'b1;
        req.bank       = `bank_sel_width'(b);
        req.pe_tag     = `pe_tag_width'(req_tag[i]);
        req.start_addr = `neighbor_addr_width'(req_start[i]);
        req.degree     = `degree_width'(req_degree[i]);
        #(clk_period / 4);
        check_stall(req_name[i], req_stall_exp[i] != 0, req_stall);
        forever begin
            check_stall(req_name[i], stall_model(b), req_stall);
            if (!req_stall) break;
            @(negedge clk);
            #(clk_period / 4);
        end
        accept_cycle = cycle + 1;
        for (int k = 0; k < words; k++) begin
            f        = '0;
            f.valid  = 1'b1;
            f.sos    = (k == 0);
            f.eos    = (k == words - 1);
            f.data   = shadow[b][(req_start[i] + k) % words_per_bank];
            if (f.eos && (req_degree[i] % 2 == 1)) begin
                f.data[`neighbor_word_width-1:`neighbor_id_width] = '0;
            end
            f.pe_tag = `pe_tag_width'(req_tag[i]);
            f.degree = `degree_width'(req_degree[i]);
            exp_flit[b].push_back(f);
            exp_due[b].push_back(accept_cycle + 3 + k);
            exp_name[b].push_back(req_name[i]);
        end
        accept_at[b]       = accept_cycle;
        last_flit_cycle[b] = accept_cycle + 3 + words - 1;
    endtask

    // flit ports are registered, so the falling edge sees settled values.
    always @(negedge clk) begin
        logic [`num_banks-1:0] busy_exp;
        if (checking) begin
            for (int b = 0; b < `num_banks; b++) begin
                // busy from the cycle after the strobe until eos is registered.
                busy_exp[b] = (cycle > accept_at[b]) && (cycle < last_flit_cycle[b]);
                if (exp_due[b].size() > 0 && exp_due[b][0] == cycle) begin
                    check_flit(exp_name[b][0], exp_flit[b][0], flits[b]);
                    void'(exp_flit[b].pop_front());
                    void'(exp_due[b].pop_front());
                    void'(exp_name[b].pop_front());
                end else begin
                    check_flit($sformatf("idle_bank%0d", b), neighbor_flit_t'(0), flits[b]);
                end
            end
            check_busy($sformatf("busy_cycle%0d", cycle), busy_exp, bank_busy);
        end
    end

    initial begin
        int total_loads;
        void'($urandom(32'h2c7f_c565));
        reset = 1'b1;
        req   = '0;
        load  = '0;
        cycle = 0;
        checking = 1'b0;
        run_passed = 1'b0;
        fail_reported = 1'b0;
        watchdog_cycles = 0;
        for (int b = 0; b < `num_banks; b++) begin
            last_flit_cycle[b] = -1;
            accept_at[b]       = -1;
        end
        read_cases();
        total_loads = req_name.size();
        foreach (load_count[i]) total_loads += load_count[i];
        watchdog_cycles = req_name.size() * 20 + total_loads + 50;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int b = 0; b < `num_banks; b++) begin
            check_flit("reset_state", neighbor_flit_t'(0), flits[b]);
        end
        check_stall("reset_state", 1'b0, req_stall);
        check_busy("reset_state", '0, bank_busy);
        checking = 1'b1;
        load_memories();
        for (int i = 0; i < req_name.size(); i++) begin
            issue_request(i);
        end
        @(negedge clk);
        req = '0;
        while (exp_due[0].size() + exp_due[1].size() + exp_due[2].size()
               + exp_due[3].size() > 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);   // no stray flits after the last list.
        if (!fail_reported) begin
            run_passed = 1'b1;
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", watchdog_cycles);
        report_failure();
    end

    // an assertion stop skips the normal end of the run.
    final begin
        if (!run_passed && !fail_reported) begin
            $display("Testbench failed");
        end
    end

endmodule

//--- testbench/neighbor_cases.txt
# L bank first_addr word_count pattern_base      (all hex)
# R name bank start_addr degree pe_tag stall_expected   (numbers hex)
L 0 00 01 1a5
L 0 02 05 2b6
L 0 28 04 0c7
L 1 04 01 311
L 1 30 06 14e
L 2 08 03 2d2
L 2 38 04 07b
L 3 10 08 3e9
L 3 20 03 1f0
R short_d1 0 00 1 0 0
R short_d2 1 04 2 1 0
R long_d5 2 08 5 2 0
R long_d15 3 10 f 3 0
R stall_d6 3 20 6 1 1
R long_d8 0 28 8 2 0
R long_d11 1 30 b 0 0
R odd_d7 2 38 7 3 0
R tag_d9 0 02 9 3 1

//--- files.f
+incdir+include
logic/neighbor_pkg.sv
logic/neighbor_mem_cntl.sv
logic/neighbor_bank_cntl.sv
logic/neighbor_sram.sv
logic/neighbor_fetch_top.sv
testbench/neighbor_fetch_asserts.sv
testbench/neighbor_fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -sv -f files.f --top-module neighbor_fetch_tb -o neighbor_fetch_sim

output=$(./obj_dir/neighbor_fetch_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "Testbench passed"; then
    exit 0
else
    exit 1
fi
